// File: aprSubsystem.f
+incdir+design
design/ks10Pkg.sv
design/intrCapture.sv
design/intervalTimer.sv
design/aprDevice.sv
design/aprSubsystem.sv
tests/aprSubsystemTb.sv

// File: design/aprDevice.sv
`timescale 1ns/1ps

`include "ks10_consts.svh"

module aprDevice
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     clken,
   input  ks10Pkg::cromSpec         spec,
   input  ks10Pkg::dpWord           dp,
   input  ks10Pkg::intrPulses       pending,
   output logic                     consume,
   output ks10Pkg::aprFlags         aprStatus,
   output logic [`APR_LEVELS:1]     aprIntr
);

   ////////////////////////////////////////////////////////////
   // Microcode decode
   ////////////////////////////////////////////////////////////

   logic specLoadApr;
   logic specAprFlags;

   assign specLoadApr  = spec.specEn20 && (spec.specSel == `SPEC_SEL_LOADAPR);
   assign specAprFlags = spec.specEn20 && (spec.specSel == `SPEC_SEL_APRFLAGS);

   // Tells the capture block its held levels are merged this edge
   assign consume = clken && specAprFlags;

   ////////////////////////////////////////////////////////////
   // Enable register
   ////////////////////////////////////////////////////////////

   logic       trapEn;
   logic       pageEn;
   logic [7:0] aprEn;
   logic       swInt;
   logic [2:0] intrLevel;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         trapEn    <= 1'b0;
         pageEn    <= 1'b0;
         aprEn     <= '0;
         swInt     <= 1'b0;
         intrLevel <= '0;
      end
      else if (clken && specLoadApr)
      begin
         trapEn    <= dp.loadApr.trapEn;
         pageEn    <= dp.loadApr.pageEn;
         aprEn     <= dp.loadApr.aprEn;
         swInt     <= dp.loadApr.swInt;
         intrLevel <= dp.loadApr.intrLevel;
      end
   end

   ////////////////////////////////////////////////////////////
   // Flag register
   ////////////////////////////////////////////////////////////

   logic [7:0] flags;
   logic [7:0] forceMask;

   // Captured interrupts override the data path bit
   // Flags 24, 25, 28 and 29 have no source and just store dp
   always_comb
   begin
      forceMask                  = '0;
      forceMask[`APR_FLAG_PWR]   = pending.pwr;
      forceMask[`APR_FLAG_NXM]   = pending.nxm;
      forceMask[`APR_FLAG_TIM]   = pending.tim;
      forceMask[`APR_FLAG_CONS]  = pending.cons;
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         flags <= '0;
      end
      else if (consume)
      begin
         flags <= dp.aprFlagsIn.flagBits | forceMask;
      end
   end

   ////////////////////////////////////////////////////////////
   // Interrupt mask
   ////////////////////////////////////////////////////////////

   logic intReq;

   // Any enabled flag or the software request
   assign intReq = (|(flags & aprEn)) || swInt;

   // Status word straight from the registers
   always_comb
   begin
      aprStatus.trapEn = trapEn;
      aprStatus.pageEn = pageEn;
      aprStatus.flags  = flags;
      aprStatus.intReq = intReq;
      aprStatus.ones   = 3'b111;
   end

   ////////////////////////////////////////////////////////////
   // Priority request
   ////////////////////////////////////////////////////////////

   logic [`APR_LEVELS:1] reqDecode;

   // One-hot at the programmed level
   // Level 0 means no request even with intReq high
   always_comb
   begin
      reqDecode = '0;
      if (intReq && (intrLevel != 3'd0))
      begin
         reqDecode[intrLevel] = 1'b1;
      end
   end

   // Runs every clock and trails intReq by exactly one cycle
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         aprIntr <= '0;
      end
      else
      begin
         aprIntr <= reqDecode;
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // Never more than one level requested
   property intrOneHot;
      @(posedge clk) disable iff (rst)
         $onehot0(aprIntr);
   endproperty

   assert property (intrOneHot)
      else $error("aprDevice: more than one interrupt level asserted");

endmodule

// File: design/aprSubsystem.sv
`timescale 1ns/1ps

`include "ks10_consts.svh"

module aprSubsystem
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     clken,
   input  ks10Pkg::cromSpec         spec,
   input  ks10Pkg::dpWord           dp,
   input  ks10Pkg::intrPulses       ext,
   output ks10Pkg::aprFlags         aprStatus,
   output logic [`APR_LEVELS:1]     aprIntr
);

   import ks10Pkg::*;

   ////////////////////////////////////////////////////////////
   // Internal wiring
   ////////////////////////////////////////////////////////////

   // Timer period end, into capture
   logic      timDone;
   // APRFLAGS commit, back to capture
   logic      consume;
   // Held interrupt levels, into the APR
   intrPulses pending;

   ////////////////////////////////////////////////////////////
   // Blocks
   ////////////////////////////////////////////////////////////

   // ext.tim is replaced by the timer output inside capture
   intrCapture i_intrCapture
   (
      .clk      (clk),
      .rst      (rst),
      .ext      (ext),
      .timDone  (timDone),
      .consume  (consume),
      .pending  (pending)
   );

   intervalTimer i_intervalTimer
   (
      .clk      (clk),
      .rst      (rst),
      .clken    (clken),
      .spec     (spec),
      .dp       (dp),
      .timDone  (timDone)
   );

   aprDevice i_aprDevice
   (
      .clk       (clk),
      .rst       (rst),
      .clken     (clken),
      .spec      (spec),
      .dp        (dp),
      .pending   (pending),
      .consume   (consume),
      .aprStatus (aprStatus),
      .aprIntr   (aprIntr)
   );

endmodule

// File: design/intervalTimer.sv
`timescale 1ns/1ps

`include "ks10_consts.svh"

module intervalTimer
(
   input  logic             clk,
   input  logic             rst,
   input  logic             clken,
   input  ks10Pkg::cromSpec spec,
   input  ks10Pkg::dpWord   dp,
   output logic             timDone
);

   ////////////////////////////////////////////////////////////
   // Microcode decode
   ////////////////////////////////////////////////////////////

   logic                          specLoadTim;
   logic [`KS10_TIMER_WIDTH-1:0]  period;
   logic [`KS10_TIMER_WIDTH-1:0]  count;

   // Only LOADTIM belongs to the timer
   assign specLoadTim = spec.specEn20 && (spec.specSel == `SPEC_SEL_LOADTIM);

   ////////////////////////////////////////////////////////////
   // Period register and down-counter
   ////////////////////////////////////////////////////////////

   // Count runs from the period down to 1
   // Done is flagged on the step that leaves 1, then the count reloads
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         period  <= '0;
         count   <= '0;
         timDone <= 1'b0;
      end
      else
      begin
         // Single-cycle pulse by default
         timDone <= 1'b0;
         if (clken)
         begin
            if (specLoadTim)
            begin
               // New period restarts the count from the top
               period <= dp.loadTim.period;
               count  <= dp.loadTim.period;
            end
            else if (period != '0)
            begin
               if (count == 1)
               begin
                  timDone <= 1'b1;
                  count   <= period;
               end
               else
               begin
                  count <= count - 1'b1;
               end
            end
            // Zero period leaves the timer idle
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // Back-to-back pulses only possible with a period of one
   property donePulse;
      @(posedge clk) disable iff (rst)
         (timDone && (period > 1)) |=> !timDone;
   endproperty

   assert property (donePulse)
      else $error("intervalTimer: timDone held for two cycles");

endmodule

// File: design/intrCapture.sv
`timescale 1ns/1ps

module intrCapture
(
   input  logic                clk,
   input  logic                rst,
   input  ks10Pkg::intrPulses  ext,
   input  logic                timDone,
   input  logic                consume,
   output ks10Pkg::intrPulses  pending
);

   import ks10Pkg::*;

   ////////////////////////////////////////////////////////////
   // Event collection
   ////////////////////////////////////////////////////////////

   intrPulses events;

   // External sources pass through
   // Timer slot comes from the interval timer, not the pins
   always_comb
   begin
      events.pwr  = ext.pwr;
      events.nxm  = ext.nxm;
      events.cons = ext.cons;
      events.tim  = timDone;
   end

   ////////////////////////////////////////////////////////////
   // Sticky pending bits
   ////////////////////////////////////////////////////////////

   // Capture is not tied to clken
   // External pulses may arrive while microcode is stalled
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         pending <= '0;
      end
      else if (consume)
      begin
         // Old levels are used up by APRFLAGS
         // A pulse in this same cycle survives for the next one
         pending <= events;
      end
      else
      begin
         pending <= pending | events;
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // A held level only drops after an APRFLAGS commit
   property pendingHeld;
      @(posedge clk) disable iff (rst)
         !consume |=> ((pending & $past(pending)) == $past(pending));
   endproperty

   assert property (pendingHeld)
      else $error("intrCapture: pending bit cleared without consume");

endmodule

// File: design/ks10Pkg.sv
`include "ks10_consts.svh"

package ks10Pkg;

   ////////////////////////////////////////////////////////////
   // Control ROM special-function field
   ////////////////////////////////////////////////////////////

   // Group enable plus function select
   typedef struct packed
   {
      logic                              specEn20;
      logic [`KS10_SPEC_SEL_WIDTH-1:0]   specSel;
   } cromSpec;

   ////////////////////////////////////////////////////////////
   // Data-path word as seen by the APR functions
   ////////////////////////////////////////////////////////////

   // One 36-bit word, field layout depends on the active function
   typedef union packed
   {
      // LOADAPR layout, architectural bits 22 to 35
      struct packed
      {
         logic [`KS10_WORD_WIDTH-15:0]   unused;
         logic                           trapEn;
         logic                           pageEn;
         logic [7:0]                     aprEn;
         logic                           swInt;
         logic [2:0]                     intrLevel;
      } loadApr;

      // APRFLAGS layout, flags live in bits 24 to 31
      struct packed
      {
         logic [23:0]                    unusedHi;
         logic [7:0]                     flagBits;
         logic [3:0]                     unusedLo;
      } aprFlagsIn;

      // LOADTIM layout, period in the low bits
      struct packed
      {
         logic [`KS10_WORD_WIDTH-`KS10_TIMER_WIDTH-1:0] unused;
         logic [`KS10_TIMER_WIDTH-1:0]                  period;
      } loadTim;
   } dpWord;

   ////////////////////////////////////////////////////////////
   // Readable APR status word, bits 22 to 35
   ////////////////////////////////////////////////////////////

   typedef struct packed
   {
      logic       trapEn;
      logic       pageEn;
      // 24, 25, power, NXM, 28, 29, timer, console
      logic [7:0] flags;
      logic       intReq;
      // Always read back as ones
      logic [2:0] ones;
   } aprFlags;

   // Interrupt sources, used both for events and held levels
   typedef struct packed
   {
      logic pwr;
      logic nxm;
      logic cons;
      logic tim;
   } intrPulses;

endpackage

// File: design/ks10_consts.svh
`ifndef KS10_CONSTS_SVH
`define KS10_CONSTS_SVH

////////////////////////////////////////////////////////////
// Data path and control ROM widths
////////////////////////////////////////////////////////////

`define KS10_WORD_WIDTH      36
`define KS10_SPEC_SEL_WIDTH  5

// Special-function select codes decoded by the APR and timer
`define SPEC_SEL_LOADAPR     5'o23
`define SPEC_SEL_APRFLAGS    5'o31
`define SPEC_SEL_LOADTIM     5'o15

////////////////////////////////////////////////////////////
// Interval timer and interrupt levels
////////////////////////////////////////////////////////////

`define KS10_TIMER_WIDTH     12

// Priority levels 1 to 7, level 1 is highest
`define APR_LEVELS           7

////////////////////////////////////////////////////////////
// Flag positions within the 8-bit flag field
////////////////////////////////////////////////////////////

// Bit 7 is architectural flag 24, bit 0 is flag 31
`define APR_FLAG_PWR         5
`define APR_FLAG_NXM         4
`define APR_FLAG_TIM         1
`define APR_FLAG_CONS        0

`endif

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module aprSubsystemTb \
   -f aprSubsystem.f \
   --Mdir obj_dir

output=$(./obj_dir/VaprSubsystemTb)
echo "$output"

if grep -qx "=== PASS ===" <<< "$output"; then
   exit 0
else
   exit 1
fi

// File: tests/aprSubsystemTb.sv
`timescale 1ns/1ps

`include "ks10_consts.svh"

module aprSubsystemTb;

   import ks10Pkg::*;

   // Model of the APR registers plus the registered request
   typedef struct packed
   {
      logic                 trapEn;
      logic                 pageEn;
      logic [7:0]           aprEn;
      logic                 swInt;
      logic [2:0]           level;
      logic [7:0]           flags;
      logic [`APR_LEVELS:1] intr;
   } modelState;

   logic                 clk;
   logic                 rst;
   logic                 clken;
   cromSpec              spec;
   dpWord                dp;
   intrPulses            ext;
   aprFlags              aprStatus;
   logic [`APR_LEVELS:1] aprIntr;

   integer               seed;
   string                testName;
   int                   flagErrors;
   int                   intrErrors;
   int                   otherErrors;

   // Reference model state
   modelState            mState;
   intrPulses            mPend;
   logic [`KS10_TIMER_WIDTH-1:0] mPeriod;
   int                   mElapsed;
   logic                 mDone;

   aprSubsystem i_dut
   (
      .clk       (clk),
      .rst       (rst),
      .clken     (clken),
      .spec      (spec),
      .dp        (dp),
      .ext       (ext),
      .aprStatus (aprStatus),
      .aprIntr   (aprIntr)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #10 clk = ~clk;
      end
   end

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////

   function automatic aprFlags statusWord(input logic trapEn, input logic pageEn,
                                          input logic [7:0] flags, input logic intReq);
      aprFlags s;
      s.trapEn = trapEn;
      s.pageEn = pageEn;
      s.flags  = flags;
      s.intReq = intReq;
      s.ones   = 3'b111;
      return s;
   endfunction

   // Readable word for a model state, intReq is enabled flags or swInt
   function automatic aprFlags refStatus(input modelState s);
      return statusWord(s.trapEn, s.pageEn, s.flags, (|(s.flags & s.aprEn)) || s.swInt);
   endfunction

   // One clock edge of the APR with the pending bits held before it
   function automatic modelState refStep(input modelState s, input intrPulses pend,
                                         input logic en, input cromSpec sp, input dpWord d);
      modelState n;
      aprFlags   st;
      n      = s;
      st     = refStatus(s);
      // Request register samples the old state every clock
      n.intr = '0;
      if (st.intReq && (s.level != 3'd0))
      begin
         n.intr[s.level] = 1'b1;
      end
      if (en && sp.specEn20 && (sp.specSel == `SPEC_SEL_LOADAPR))
      begin
         n.trapEn = d.loadApr.trapEn;
         n.pageEn = d.loadApr.pageEn;
         n.aprEn  = d.loadApr.aprEn;
         n.swInt  = d.loadApr.swInt;
         n.level  = d.loadApr.intrLevel;
      end
      if (en && sp.specEn20 && (sp.specSel == `SPEC_SEL_APRFLAGS))
      begin
         // dp bits, with captured sources forced on
         n.flags = d.aprFlagsIn.flagBits;
         n.flags[`APR_FLAG_PWR]  = n.flags[`APR_FLAG_PWR] | pend.pwr;
         n.flags[`APR_FLAG_NXM]  = n.flags[`APR_FLAG_NXM] | pend.nxm;
         n.flags[`APR_FLAG_CONS] = n.flags[`APR_FLAG_CONS] | pend.cons;
         n.flags[`APR_FLAG_TIM]  = n.flags[`APR_FLAG_TIM] | pend.tim;
      end
      return n;
   endfunction

   always @(posedge clk or posedge rst)
   begin
      intrPulses evt;
      logic      consumeNow;
      if (rst)
      begin
         mState   = '0;
         mPend    = '0;
         mPeriod  = '0;
         mElapsed = 0;
         mDone    = 1'b0;
      end
      else
      begin
         consumeNow = clken && spec.specEn20 && (spec.specSel == `SPEC_SEL_APRFLAGS);
         // Timer slot of ext is not a source
         evt.pwr    = ext.pwr;
         evt.nxm    = ext.nxm;
         evt.cons   = ext.cons;
         evt.tim    = mDone;
         mState     = refStep(mState, mPend, clken, spec, dp);
         mPend      = consumeNow ? evt : (mPend | evt);
         // Timer counts enabled cycles since load or since the last period end
         mDone      = 1'b0;
         if (clken && spec.specEn20 && (spec.specSel == `SPEC_SEL_LOADTIM))
         begin
            mPeriod  = dp.loadTim.period;
            mElapsed = 0;
         end
         else if (clken && (mPeriod != '0))
         begin
            mElapsed++;
            if (mElapsed == int'(mPeriod))
            begin
               mDone    = 1'b1;
               mElapsed = 0;
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////

   task automatic checkFlags(input string name, input aprFlags expected, input aprFlags actual);
      if (actual !== expected)
      begin
         $display("CHECK FAILED %s: aprStatus expected %h, actual %h", name, expected, actual);
         flagErrors++;
      end
   endtask

   task automatic checkIntr(input string name, input logic [`APR_LEVELS:1] expected,
                            input logic [`APR_LEVELS:1] actual);
      if (actual !== expected)
      begin
         $display("CHECK FAILED %s: aprIntr expected %b, actual %b", name, expected, actual);
         intrErrors++;
      end
   endtask

   task automatic checkCycles(input string name, input int expected, input int actual);
      if (actual != expected)
      begin
         $display("CHECK FAILED %s: cycles expected %0d, actual %0d", name, expected, actual);
         otherErrors++;
      end
   endtask

   // Model against DUT on every falling edge
   always @(negedge clk)
   begin
      if (!rst)
      begin
         checkFlags(testName, refStatus(mState), aprStatus);
         checkIntr(testName, mState.intr, aprIntr);
      end
   end

   ////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////

   function automatic dpWord randWord();
      logic [63:0] r;
      r = {$random(seed), $random(seed)};
      return r[`KS10_WORD_WIDTH-1:0];
   endfunction

   task automatic applyOp(input logic en, input logic specOn, input logic [4:0] sel,
                          input dpWord d, input intrPulses e);
      @(negedge clk);
      clken         = en;
      spec.specEn20 = specOn;
      spec.specSel  = sel;
      dp            = d;
      ext           = e;
   endtask

   task automatic microOp(input logic [4:0] sel, input dpWord d);
      applyOp(1'b1, 1'b1, sel, d, '0);
   endtask

   task automatic idleCycles(input int n);
      repeat (n)
      begin
         applyOp(1'b1, 1'b0, 5'd0, randWord(), '0);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      intrPulses            pulses;
      dpWord                word;
      logic [31:0]          r;
      logic [`APR_LEVELS:1] expIntr;
      logic                 fired;
      int                   cycles;
      int                   period;
      seed        = 32'h6cf2c2ca;
      flagErrors  = 0;
      intrErrors  = 0;
      otherErrors = 0;
      testName    = "reset";
      rst         = 1'b1;
      clken       = 1'b0;
      spec        = '0;
      dp          = '0;
      ext         = '0;
      repeat (2) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      checkFlags("reset", statusWord(1'b0, 1'b0, 8'h00, 1'b0), aprStatus);
      checkIntr("reset", '0, aprIntr);

      // Mixed ops, clken low and foreign selects, checked by the model
      testName = "random ops";
      for (int i = 0; i < 80; i++)
      begin
         r      = $random(seed);
         pulses = (r[6:4] == 3'd0) ? intrPulses'(r[11:8]) : '0;
         case (r[1:0])
            2'd0: applyOp(1'b1, 1'b1, `SPEC_SEL_LOADAPR, randWord(), pulses);
            2'd1: applyOp(1'b1, 1'b1, `SPEC_SEL_APRFLAGS, randWord(), pulses);
            2'd2: applyOp(1'b1, r[2], r[20:16], randWord(), pulses);
            default: applyOp(1'b0, 1'b1, r[3] ? `SPEC_SEL_LOADAPR : `SPEC_SEL_APRFLAGS,
                             randWord(), pulses);
         endcase
      end

      // Stop the timer and drain whatever was captured
      testName = "interrupt request";
      microOp(`SPEC_SEL_LOADTIM, '0);
      idleCycles(1);
      microOp(`SPEC_SEL_APRFLAGS, '0);
      microOp(`SPEC_SEL_APRFLAGS, '0);
      for (int lvl = 0; lvl <= `APR_LEVELS; lvl++)
      begin
         word                   = randWord();
         word.loadApr.intrLevel = lvl[2:0];
         expIntr                = '0;
         if (word.loadApr.swInt && (lvl != 0))
         begin
            expIntr[lvl] = 1'b1;
         end
         microOp(`SPEC_SEL_LOADAPR, word);
         idleCycles(1);
         checkFlags(testName, statusWord(word.loadApr.trapEn, word.loadApr.pageEn, 8'h00,
                                         word.loadApr.swInt), aprStatus);
         // Request trails the status by one cycle
         idleCycles(1);
         checkIntr(testName, expIntr, aprIntr);
      end

      // Pulses held until the next APRFLAGS
      testName = "captured interrupts";
      microOp(`SPEC_SEL_LOADAPR, '0);
      applyOp(1'b1, 1'b0, 5'd0, '0, intrPulses'(4'b1111));
      idleCycles(2);
      microOp(`SPEC_SEL_APRFLAGS, '0);
      idleCycles(1);
      checkFlags(testName, statusWord(1'b0, 1'b0, (8'h01 << `APR_FLAG_PWR) |
                 (8'h01 << `APR_FLAG_NXM) | (8'h01 << `APR_FLAG_CONS), 1'b0), aprStatus);
      // Pulse together with consume survives one more operation
      applyOp(1'b1, 1'b1, `SPEC_SEL_APRFLAGS, '0, intrPulses'(4'b1000));
      idleCycles(1);
      checkFlags(testName, statusWord(1'b0, 1'b0, 8'h00, 1'b0), aprStatus);
      microOp(`SPEC_SEL_APRFLAGS, '0);
      idleCycles(1);
      checkFlags(testName, statusWord(1'b0, 1'b0, 8'h01 << `APR_FLAG_PWR, 1'b0), aprStatus);

      // Timer with its flag enabled at level 3
      testName = "timer";
      word                               = '0;
      word.loadApr.aprEn[`APR_FLAG_TIM]  = 1'b1;
      word.loadApr.intrLevel             = 3'd3;
      microOp(`SPEC_SEL_LOADAPR, word);
      microOp(`SPEC_SEL_APRFLAGS, '0);
      period                             = 3 + ($unsigned($random(seed)) % 8);
      word                               = '0;
      word.loadTim.period                = period[`KS10_TIMER_WIDTH-1:0];
      microOp(`SPEC_SEL_LOADTIM, word);
      cycles = 0;
      while (!i_dut.timDone && (cycles < 4 * period + 8))
      begin
         idleCycles(1);
         cycles++;
      end
      if (!i_dut.timDone)
      begin
         $display("Timer never signalled the end of its period of %0d cycles", period);
         otherErrors++;
      end
      else
      begin
         // First counted falling edge comes right after the load edge
         checkCycles(testName, period, cycles - 1);
      end
      idleCycles(1);
      microOp(`SPEC_SEL_APRFLAGS, '0);
      idleCycles(1);
      checkFlags(testName, statusWord(1'b0, 1'b0, 8'h01 << `APR_FLAG_TIM, 1'b1), aprStatus);
      idleCycles(1);
      checkIntr(testName, 7'b0000100, aprIntr);

      // Zero period keeps the timer silent
      testName = "timer stopped";
      microOp(`SPEC_SEL_LOADTIM, '0);
      idleCycles(1);
      microOp(`SPEC_SEL_APRFLAGS, '0);
      microOp(`SPEC_SEL_APRFLAGS, '0);
      fired  = 1'b0;
      cycles = 0;
      while (cycles < 4 * period + 8)
      begin
         idleCycles(1);
         fired = fired | i_dut.timDone;
         cycles++;
      end
      if (fired)
      begin
         $display("Timer fired although its period was loaded as zero");
         otherErrors++;
      end
      microOp(`SPEC_SEL_APRFLAGS, '0);
      idleCycles(1);
      checkFlags(testName, statusWord(1'b0, 1'b0, 8'h00, 1'b0), aprStatus);
      idleCycles(2);

      $display("Errors: flags %0d, interrupt %0d, other %0d",
               flagErrors, intrErrors, otherErrors);
      if ((flagErrors + intrErrors + otherErrors) == 0)
      begin
         $display("=== PASS ===");
      end
      else
      begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule
